// File: design/baud_tick_gen.sv
`timescale 1ns/100ps
`default_nettype none

// Oversample tick divider, runs only while the receiver holds enable high
module baud_tick_gen (
    input  logic Clk,
    input  logic Rst,
    input  logic enable,
    output logic tick
);
    import uart_rx_pkg::*;

    logic [TICK_CNT_W-1:0] clk_cnt;  // Clocks since the last tick
    logic                  wrap;     // Divider at its last count

    assign wrap = (clk_cnt == TICK_CNT_W'(CLKS_PER_TICK - 1));

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            clk_cnt <= '0;
        end else if (!enable) begin
            clk_cnt <= '0;                  // Restart so the next frame is aligned to its start edge
        end else if (wrap) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // One clock wide, once per CLKS_PER_TICK clocks
    assign tick = enable && wrap;

    // A disabled cycle holds the next tick off for a full divider period
    a_tick_gated: assert property (
        @(posedge Clk) disable iff (Rst)
        !enable |-> !tick [*CLKS_PER_TICK]
    ) else $error("tick too soon after enable was low");

endmodule

`default_nettype wire

// File: design/rx_fifo.sv
`timescale 1ns/100ps
`default_nettype none

// Receive FIFO whose head word is visible on rd_data ahead of the read strobe
module rx_fifo (
    input  logic                  Clk,
    input  logic                  Rst,
    input  logic                  wr_en,
    input  uart_rx_pkg::rx_data_t wr_data,
    input  logic                  rd_en,
    output uart_rx_pkg::rx_data_t rd_data,
    output logic                  empty,
    output logic                  full,
    output logic                  overflow
);
    import uart_rx_pkg::*;

    rx_data_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;   // Words held
    logic             do_wr;   // Accepted push
    logic             do_rd;   // Accepted pop

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(FIFO_DEPTH));

    // The serial side cannot wait, so a push into a full FIFO is lost
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;   // Reads of an empty FIFO do nothing

    assign rd_data = mem[rd_ptr];

    always_ff @(posedge Clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Push and pop together leave it unchanged
            endcase
            if (wr_en && full) begin
                overflow <= 1'b1;          // Held until reset
            end
        end
    end

    a_count_bound: assert property (
        @(posedge Clk) disable iff (Rst)
        count <= CNT_W'(FIFO_DEPTH)
    ) else $error("FIFO count above depth");

endmodule

`default_nettype wire

// File: design/uart_rx_frame.sv
`timescale 1ns/100ps
`default_nettype none

// Frame receiver that finds the start bit, samples each bit at mid-point and checks the frame
module uart_rx_frame (
    input  logic                    Clk,
    input  logic                    Rst,
    input  logic                    rx_in,
    input  logic                    tick,
    output logic                    enable,
    output logic                    rts,
    output logic                    data_rdy,
    output logic                    err_strobe,
    output uart_rx_pkg::rx_result_t result
);
    import uart_rx_pkg::*;

    typedef enum logic [2:0] {
        IDLE,       // Waiting for a start edge with rts high
        RECEIVING,  // Sampling the frame
        OUTPUT,     // Data byte copied out and its parity computed
        CHECK,      // Error flags set
        FINISH      // Result strobe while the counters clear
    } rx_state_t;

    rx_state_t             state;
    logic                  line_idle;    // Line seen high since the last frame ended
    logic                  start_det;    // Registered start edge
    logic [OVS_CNT_W-1:0]  tick_cnt;     // Tick position within the current bit
    logic [BIT_CNT_W-1:0]  bit_cnt;      // Samples taken so far
    logic [FRAME_BITS-1:0] rx_buf;       // Start bit ends up in the MSB, last stop bit in the LSB
    logic                  sample;       // Mid-bit point of the current bit
    logic                  last_sample;  // Mid-point of the final stop bit
    logic                  data_xor;     // XOR over the received data bits
    rx_data_t              rx_byte;
    rx_err_t               rx_err;

    // A line held low past the end of a frame (break, low stop bit) must go high
    // again before a new start edge is accepted
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            line_idle <= 1'b0;
            start_det <= 1'b0;
        end else begin
            if (state == FINISH) begin
                line_idle <= 1'b0;
            end else if (state == IDLE && rx_in) begin
                line_idle <= 1'b1;
            end
            start_det <= (state == IDLE) && line_idle && !rx_in;  // One clock behind the line
        end
    end

    // 8th tick of each bit is the sample point
    assign sample      = tick && (tick_cnt == OVS_CNT_W'(OVERSAMPLE / 2 - 1));
    assign last_sample = sample && (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (state == FINISH) begin
            tick_cnt <= '0;                    // Ready for the next frame
            bit_cnt  <= '0;
        end else if (state == RECEIVING && tick) begin
            tick_cnt <= tick_cnt + 1'b1;       // Wraps once per bit after OVERSAMPLE ticks
            if (sample) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Samples shift in from the LSB, so the first data bit (the MSB) lands just below the start bit
    always_ff @(posedge Clk) begin
        if (state == RECEIVING && sample) begin
            rx_buf <= {rx_buf[FRAME_BITS-2:0], rx_in};
        end
    end

    // Frame sequencing
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start_det) begin
                        state <= RECEIVING;
                    end
                end
                RECEIVING: begin
                    if (last_sample) begin
                        state <= OUTPUT;       // Buffer is complete on this edge
                    end
                end
                OUTPUT:  state <= CHECK;
                CHECK:   state <= FINISH;
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Byte goes out one cycle before its strobe and holds until the next frame
    always_ff @(posedge Clk) begin
        if (state == OUTPUT) begin
            rx_byte  <= rx_buf[FRAME_BITS-2 -: DATA_BITS];
            data_xor <= ^rx_buf[FRAME_BITS-2 -: DATA_BITS];
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            rx_err <= '0;
        end else if (state == CHECK) begin
            rx_err.brk    <= (rx_buf == '0);                   // Line never went high
            rx_err.parity <= (rx_buf[STOP_BITS] != data_xor);  // Even parity over the data
            rx_err.frame  <= (rx_buf[STOP_BITS-1:0] != '1);    // Any stop bit low
        end
    end

    assign result = '{data: rx_byte, err: rx_err};

    // Tick divider runs through the checks and is released in FINISH
    assign enable = (state == RECEIVING) || (state == OUTPUT) || (state == CHECK);
    assign rts    = (state == IDLE);       // Only an idle receiver invites the next frame

    // Clean frames are pushed and bad frames only reported
    assign data_rdy   = (state == FINISH) && (rx_err == '0);
    assign err_strobe = (state == FINISH) && (rx_err != '0);

    a_one_strobe: assert property (
        @(posedge Clk) disable iff (Rst)
        !(data_rdy && err_strobe)
    ) else $error("data_rdy and err_strobe together");

    // The tick generator only runs while the host sees the receiver busy
    a_busy_rts: assert property (
        @(posedge Clk) disable iff (Rst)
        enable |-> !rts
    ) else $error("rts high while the tick generator runs");

endmodule

`default_nettype wire

// File: design/uart_rx_pkg.sv
`default_nettype none

// Shared frame shape and result types of the UART receive path
package uart_rx_pkg;

    // Frame shape, fixed at build time
    localparam int DATA_BITS     = 8;   // Data bits per frame, MSB first on the line
    localparam int STOP_BITS     = 2;   // Stop bits closing each frame
    localparam int OVERSAMPLE    = 16;  // Oversample ticks per bit
    localparam int CLKS_PER_TICK = 4;   // System clocks per oversample tick, 64 clocks per bit

    // Start + data + parity + stop samples held per frame
    localparam int FRAME_BITS = 1 + DATA_BITS + 1 + STOP_BITS;

    localparam int FIFO_DEPTH = 8;      // Receive FIFO entries

    // Counter and pointer widths derived from the shape above
    localparam int TICK_CNT_W = $clog2(CLKS_PER_TICK);   // Divider count
    localparam int OVS_CNT_W  = $clog2(OVERSAMPLE);      // Ticks within one bit
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS + 1);  // Samples taken, up to FRAME_BITS
    localparam int PTR_W      = $clog2(FIFO_DEPTH);      // FIFO read and write pointers
    localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);  // FIFO occupancy, up to FIFO_DEPTH

    typedef logic [DATA_BITS-1:0] rx_data_t;  // One received byte

    // Error flags of one frame
    typedef struct packed {
        logic brk;     // Every sampled bit low
        logic parity;  // Parity bit differs from the XOR of the data bits
        logic frame;   // A stop bit was sampled low
    } rx_err_t;

    // Everything the frame receiver reports about one frame
    typedef struct packed {
        rx_data_t data;
        rx_err_t  err;
    } rx_result_t;

endpackage

`default_nettype wire

// File: design/uart_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

// UART receive subsystem: tick divider, frame receiver and receive FIFO
module uart_rx_top (
    input  logic                  Clk,
    input  logic                  Rst,
    input  logic                  rx_in,
    input  logic                  rd_en,
    output uart_rx_pkg::rx_data_t rd_data,
    output logic                  fifo_empty,
    output logic                  fifo_full,
    output logic                  fifo_overflow,
    output logic                  rts,
    output logic                  err_strobe,
    output uart_rx_pkg::rx_err_t  err_flags
);
    import uart_rx_pkg::*;

    logic       tick;      // 16x bit-rate pulse
    logic       enable;    // Receiver busy with a frame
    logic       data_rdy;  // Clean byte ready for the FIFO
    rx_result_t result;

    baud_tick_gen u_baud_tick_gen (
        .Clk    (Clk),
        .Rst    (Rst),
        .enable (enable),
        .tick   (tick)
    );

    uart_rx_frame u_uart_rx_frame (
        .Clk        (Clk),
        .Rst        (Rst),
        .rx_in      (rx_in),
        .tick       (tick),
        .enable     (enable),
        .rts        (rts),
        .data_rdy   (data_rdy),
        .err_strobe (err_strobe),
        .result     (result)
    );

    // Only error-free bytes reach the FIFO
    rx_fifo u_rx_fifo (
        .Clk      (Clk),
        .Rst      (Rst),
        .wr_en    (data_rdy),
        .wr_data  (result.data),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .empty    (fifo_empty),
        .full     (fifo_full),
        .overflow (fifo_overflow)
    );

    assign err_flags = result.err;   // Valid with err_strobe

endmodule

`default_nettype wire

// File: filelist.f
design/uart_rx_pkg.sv
design/baud_tick_gen.sv
design/uart_rx_frame.sv
design/rx_fifo.sv
design/uart_rx_top.sv
testbench/uart_rx_tb.sv

// File: testbench/uart_rx_patterns.txt
# Columns: data byte (hex), parity bit sent, stop bits sent (first, second), line held low
# Even parity is correct when the parity bit equals the XOR of the data bits
a5 0 11 0
3c 0 11 0
01 1 11 0
ff 0 11 0
80 1 11 0
5b 1 11 0
00 0 11 0
96 1 11 0
4e 0 10 0
c3 0 01 0
00 0 00 1
7e 0 11 0
81 0 11 0
2d 0 11 0
6a 1 00 0
12 0 11 0
e7 0 11 0
34 1 11 0
9a 0 11 0
0f 0 11 0
c8 1 11 0
71 0 11 0
b6 1 11 0
5d 1 11 0

// File: testbench/uart_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_tb;
    import uart_rx_pkg::*;

    localparam int CLKS_PER_BIT   = OVERSAMPLE * CLKS_PER_TICK;  // 64 clocks per serial bit
    localparam int RESULT_TIMEOUT = 4 * CLKS_PER_BIT;            // Clocks allowed after the frame

    logic     Clk;
    logic     Rst;
    logic     rx_in;
    logic     rd_en;
    rx_data_t rd_data;
    logic     fifo_empty;
    logic     fifo_full;
    logic     fifo_overflow;
    logic     rts;
    logic     err_strobe;
    rx_err_t  err_flags;

    rx_data_t             pat_data [$];  // One entry per pattern line
    logic                 pat_par [$];
    logic [STOP_BITS-1:0] pat_stop [$];
    logic                 pat_low [$];

    rx_data_t    exp_q [$];     // Model of the FIFO contents
    logic        exp_overflow;  // Model of the sticky overflow flag
    rx_err_t     err_q [$];     // Flags captured on each err_strobe
    logic        rts_low_seen;  // Receiver went busy during the current frame
    logic        rts_seen;      // Last sampled rts
    logic        empty_seen;    // Last sampled fifo_empty
    int          errors;
    int unsigned seed_val;

    uart_rx_top u_uart_rx_top (
        .Clk           (Clk),
        .Rst           (Rst),
        .rx_in         (rx_in),
        .rd_en         (rd_en),
        .rd_data       (rd_data),
        .fifo_empty    (fifo_empty),
        .fifo_full     (fifo_full),
        .fifo_overflow (fifo_overflow),
        .rts           (rts),
        .err_strobe    (err_strobe),
        .err_flags     (err_flags)
    );

    always #10 Clk = ~Clk;  // 20 ns period

    // DUT outputs change on the rising edge and are steady at the falling edge
    always @(negedge Clk) begin
        if (!Rst) begin
            if (!rts) begin
                rts_low_seen = 1'b1;
            end
            if (err_strobe) begin
                err_q.push_back(err_flags);  // One entry per pulse
            end
            rts_seen   = rts;
            empty_seen = fifo_empty;
        end
    end

    task automatic check_data(input string name, input rx_data_t got, input rx_data_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_err(input string name, input rx_err_t got, input rx_err_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // Flags that follow from what actually sits on the line during the frame
    function automatic rx_err_t expect_err(input rx_data_t data, input logic par,
                                           input logic [STOP_BITS-1:0] stop, input logic low);
        rx_err_t              e;
        rx_data_t             d;
        logic                 p;
        logic [STOP_BITS-1:0] s;
        d        = low ? '0 : data;
        p        = low ? 1'b0 : par;
        s        = low ? '0 : stop;
        e.brk    = (d == '0) && !p && (s == '0);  // Start bit is always low
        e.parity = (p != ^d);                     // Even parity
        e.frame  = (s != '1);
        return e;
    endfunction

    task automatic load_patterns();
        int                   fd;
        int                   n;
        int                   r;
        logic [8*128-1:0]     skip_line;
        rx_data_t             d;
        logic                 p;
        logic [STOP_BITS-1:0] s;
        logic                 l;
        fd = $fopen("testbench/uart_rx_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the pattern file");
            finish_run();
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%h %b %b %b", d, p, s, l);
                if (n == 4) begin
                    pat_data.push_back(d);
                    pat_par.push_back(p);
                    pat_stop.push_back(s);
                    pat_low.push_back(l);
                end else begin
                    r = $fgets(skip_line, fd);  // Comment line or end of file
                    if (r == 0) begin
                        break;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Sends the start bit, the data MSB first, the parity bit and the stop bits
    // for one bit time each
    task automatic send_frame(input rx_data_t data, input logic par,
                              input logic [STOP_BITS-1:0] stop, input logic low);
        logic [FRAME_BITS-1:0] bits;
        bits = low ? '0 : {1'b0, data, par, stop};
        @(negedge Clk);
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            rx_in = bits[i];
            repeat (CLKS_PER_BIT) @(negedge Clk);
        end
        rx_in = 1'b1;  // Back to idle
    endtask

    task automatic idle_gap();
        int gap;
        gap = 4 + ($urandom % 60);
        repeat (gap) @(negedge Clk);
    endtask

    // Done once the receiver is idle again and has either pushed or reported
    task automatic wait_result();
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < RESULT_TIMEOUT) begin
            @(posedge Clk);
            cycles++;
            done = rts_seen && (err_q.size() != 0 || !empty_seen);
        end
        if (!done) begin
            errors++;
            $display("Timed out waiting for the receiver to report a frame");
            finish_run();
        end
    endtask

    // Reads every modelled word back in order with the head word checked before rd_en
    task automatic drain_fifo();
        rx_data_t exp;
        while (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            @(negedge Clk);
            check_data("rd_data", rd_data, exp);
            rd_en = 1'b1;
            @(negedge Clk);
            rd_en = 1'b0;
        end
        @(negedge Clk);
        check_bit("fifo_empty", fifo_empty, 1'b1);
    endtask

    task automatic run_pattern(input int idx);
        rx_err_t exp_err;
        exp_err = expect_err(pat_data[idx], pat_par[idx], pat_stop[idx], pat_low[idx]);
        if (exp_err != '0 && exp_q.size() != 0) begin
            drain_fifo();  // A bad frame must leave an empty FIFO empty
        end
        @(negedge Clk);
        rts_low_seen = 1'b0;
        err_q.delete();
        send_frame(pat_data[idx], pat_par[idx], pat_stop[idx], pat_low[idx]);
        idle_gap();
        wait_result();
        check_bit("rts low during frame", rts_low_seen, 1'b1);
        if (exp_err != '0) begin
            if (err_q.size() != 1) begin
                errors++;
                $display("Frame %0d expected one err_strobe pulse but saw %0d", idx, err_q.size());
            end else begin
                check_err("err_flags", err_q[0], exp_err);
            end
        end else begin
            if (err_q.size() != 0) begin
                errors++;
                $display("Frame %0d is clean but err_strobe pulsed", idx);
            end
            if (exp_q.size() < FIFO_DEPTH) begin
                exp_q.push_back(pat_data[idx]);
            end else begin
                exp_overflow = 1'b1;  // The byte is lost because the FIFO was full
            end
        end
        @(negedge Clk);
        check_bit("rts", rts, 1'b1);
        check_bit("fifo_empty", fifo_empty, exp_q.size() == 0);
        check_bit("fifo_full", fifo_full, exp_q.size() == FIFO_DEPTH);
        check_bit("fifo_overflow", fifo_overflow, exp_overflow);
    endtask

    initial begin
        Clk          = 1'b0;
        Rst          = 1'b1;
        rx_in        = 1'b1;
        rd_en        = 1'b0;
        errors       = 0;
        exp_overflow = 1'b0;
        rts_low_seen = 1'b0;
        rts_seen     = 1'b0;
        empty_seen   = 1'b1;
        seed_val     = $urandom(32'h98fe);
        load_patterns();
        repeat (5) @(negedge Clk);
        Rst = 1'b0;
        repeat (4) @(negedge Clk);  // Line high long enough to be seen idle
        check_bit("rts", rts, 1'b1);
        check_bit("err_strobe", err_strobe, 1'b0);
        check_bit("fifo_empty", fifo_empty, 1'b1);
        check_bit("fifo_full", fifo_full, 1'b0);
        check_bit("fifo_overflow", fifo_overflow, 1'b0);
        for (int i = 0; i < pat_data.size(); i++) begin
            run_pattern(i);
        end
        drain_fifo();
        finish_run();
    end

endmodule

`default_nettype wire
